//--- sources.f
rtl/llc_pkg.sv
rtl/llc_sram_sp.sv
rtl/llc_write_ctrl.sv
rtl/llc_way_bank.sv
rtl/llc_evict_ways.sv
rtl/llc_localmem.sv
verification/tb_llc_localmem.sv

//--- verification/tb_llc_localmem.sv
/* llc local memory testbench */

`timescale 1ns/1ps

module tb_llc_localmem;

    localparam int NUM_WAYS       = 4;
    localparam int BANKS_PER_WAY  = 2;
    localparam int NUM_SETS       = 1 << llc_pkg::SET_BITS;
    localparam int RESET_CYCLES   = 10;
    localparam int N_RW           = 16;
    localparam int N_EVICT        = 32;
    // rough length of all tests in cycles
    localparam int EST_CYCLES     = RESET_CYCLES + 8 + 2 * N_RW + 40 + 30 + 2 * N_EVICT;
    localparam int TIMEOUT_CYCLES = 10 * EST_CYCLES;

    logic                clk;
    logic                rst;
    logic                rd_en;
    logic                wr_en;
    logic [NUM_WAYS-1:0] wr_flush;
    logic                wr_evict_en;
    llc_pkg::llc_set_t   set_addr;
    llc_pkg::llc_way_t   way_sel;
    llc_pkg::llc_entry_t wr_entry;
    llc_pkg::llc_way_t   wr_evict_way;
    llc_pkg::llc_entry_t rd_entry [NUM_WAYS];
    llc_pkg::llc_way_t   rd_evict_way;

    // scoreboard of expected contents
    llc_pkg::llc_entry_t exp_mem   [NUM_WAYS][NUM_SETS];
    logic                exp_valid [NUM_WAYS][NUM_SETS];
    llc_pkg::llc_way_t   exp_evict [NUM_SETS];

    int err_cnt   = 0;
    int check_cnt = 0;
    int cycle_cnt = 0;

    llc_localmem #(
        .NUM_WAYS      (NUM_WAYS),
        .BANKS_PER_WAY (BANKS_PER_WAY)
    ) uut (
        .clk            (clk),
        .rst            (rst),
        .rd_en_i        (rd_en),
        .wr_en_i        (wr_en),
        .wr_flush_i     (wr_flush),
        .wr_evict_en_i  (wr_evict_en),
        .set_i          (set_addr),
        .way_i          (way_sel),
        .wr_entry_i     (wr_entry),
        .wr_evict_way_i (wr_evict_way),
        .rd_entry_o     (rd_entry),
        .rd_evict_way_o (rd_evict_way)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Something failed");
            $finish;
        end
    end

    // inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    function automatic llc_pkg::llc_entry_t rand_entry();
        llc_pkg::llc_entry_t e;
        e.line    = {$urandom, $urandom, $urandom, $urandom};
        e.sharers = llc_pkg::llc_sharers_t'($urandom);
        e.hprot   = 1'($urandom);
        e.dirty   = 1'($urandom);
        e.state   = llc_pkg::llc_state_t'($urandom);
        e.owner   = llc_pkg::llc_owner_t'($urandom);
        e.tag     = llc_pkg::llc_tag_t'($urandom);
        return e;
    endfunction

    task automatic write_entry(input llc_pkg::llc_set_t s, input llc_pkg::llc_way_t w,
                               input llc_pkg::llc_entry_t e);
        wr_en    = 1'b1;
        set_addr = s;
        way_sel  = w;
        wr_entry = e;
        next_cycle();
        wr_en = 1'b0;
        exp_mem[w][s]   = e;
        exp_valid[w][s] = 1'b1;
    endtask

    task automatic flush_ways(input llc_pkg::llc_set_t s, input logic [NUM_WAYS-1:0] flags,
                              input llc_pkg::llc_entry_t e);
        wr_flush = flags;
        set_addr = s;
        wr_entry = e;
        next_cycle();
        wr_flush = '0;
        // a flush rewrites state, dirty and sharers only
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (flags[w]) begin
                exp_mem[w][s].state   = e.state;
                exp_mem[w][s].dirty   = e.dirty;
                exp_mem[w][s].sharers = e.sharers;
            end
        end
    endtask

    task automatic check_set(input string name, input llc_pkg::llc_set_t s);
        rd_en    = 1'b1;
        set_addr = s;
        next_cycle();
        rd_en = 1'b0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (exp_valid[w][s]) begin
                check_cnt++;
                a_entry: assert (rd_entry[w] === exp_mem[w][s]) else begin
                    err_cnt++;
                    $display("ERR %s way %0d set %0d expected %h actual %h",
                             name, w, s, exp_mem[w][s], rd_entry[w]);
                end
            end
        end
    endtask

    task automatic check_evict(input string name, input llc_pkg::llc_way_t exp);
        check_cnt++;
        a_evict: assert (rd_evict_way === exp) else begin
            err_cnt++;
            $display("ERR %s set %0d expected %0d actual %0d", name, set_addr, exp, rd_evict_way);
        end
    endtask

    task automatic test_reset_evict();
        for (int s = 0; s < 8; s++) begin
            set_addr = llc_pkg::llc_set_t'(s);
            next_cycle();
            check_evict("reset_evict", '0);
        end
    endtask

    task automatic test_write_read();
        llc_pkg::llc_set_t s;
        llc_pkg::llc_way_t w;
        repeat (N_RW) begin
            s = llc_pkg::llc_set_t'($urandom_range(NUM_SETS - 1, 0));
            w = llc_pkg::llc_way_t'($urandom_range(NUM_WAYS - 1, 0));
            write_entry(s, w, rand_entry());
            check_set("write_read", s);
        end
    endtask

    task automatic test_isolation();
        llc_pkg::llc_set_t   s_lo;
        llc_pkg::llc_set_t   s_hi;
        llc_pkg::llc_entry_t e;
        s_lo = llc_pkg::llc_set_t'($urandom_range(NUM_SETS / 2 - 1, 0));
        s_hi = s_lo;
        s_hi[llc_pkg::SET_BITS-1] = 1'b1;
        // low tag bits keep every entry distinct
        for (int w = 0; w < NUM_WAYS; w++) begin
            e = rand_entry();
            e.tag[2:0] = {1'b0, 2'(w)};
            write_entry(s_lo, llc_pkg::llc_way_t'(w), e);
            e = rand_entry();
            e.tag[2:0] = {1'b1, 2'(w)};
            write_entry(s_hi, llc_pkg::llc_way_t'(w), e);
        end
        check_set("isolation", s_lo);
        check_set("isolation", s_hi);
        write_entry(s_lo, 2'd2, rand_entry());
        check_set("isolation_one_way", s_lo);
        check_set("isolation_one_way", s_hi);
    endtask

    task automatic test_flush();
        llc_pkg::llc_set_t s;
        s = llc_pkg::llc_set_t'($urandom_range(NUM_SETS - 1, 0));
        for (int w = 0; w < NUM_WAYS; w++) begin
            write_entry(s, llc_pkg::llc_way_t'(w), rand_entry());
        end
        flush_ways(s, 4'b0101, rand_entry());
        check_set("flush", s);
        s[llc_pkg::SET_BITS-1] = ~s[llc_pkg::SET_BITS-1];
        for (int w = 0; w < NUM_WAYS; w++) begin
            write_entry(s, llc_pkg::llc_way_t'(w), rand_entry());
        end
        flush_ways(s, 4'b1010, rand_entry());
        check_set("flush_other_bank", s);
    endtask

    task automatic test_evict();
        llc_pkg::llc_set_t s;
        llc_pkg::llc_way_t w;
        repeat (N_EVICT) begin
            s = llc_pkg::llc_set_t'($urandom_range(NUM_SETS - 1, 0));
            w = llc_pkg::llc_way_t'($urandom_range(NUM_WAYS - 1, 0));
            wr_evict_en  = 1'b1;
            set_addr     = s;
            wr_evict_way = w;
            next_cycle();
            wr_evict_en  = 1'b0;
            exp_evict[s] = w;
            // output register picks up the new value one edge later
            next_cycle();
            check_evict("evict", exp_evict[s]);
        end
    endtask

    initial begin
        void'($urandom(68377));
        rst          = 1'b0;
        rd_en        = 1'b0;
        wr_en        = 1'b0;
        wr_flush     = '0;
        wr_evict_en  = 1'b0;
        set_addr     = '0;
        way_sel      = '0;
        wr_entry     = '0;
        wr_evict_way = '0;
        for (int s = 0; s < NUM_SETS; s++) begin
            exp_evict[s] = '0;
            for (int w = 0; w < NUM_WAYS; w++) begin
                exp_valid[w][s] = 1'b0;
            end
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b1;

        test_reset_evict();
        test_write_read();
        test_isolation();
        test_flush();
        test_evict();

        $display("checks %0d, errors %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- rtl/llc_localmem.sv
/* llc local memory */

`timescale 1ns/1ps

module llc_localmem #(
    parameter int NUM_WAYS      = 4,
    parameter int BANKS_PER_WAY = 2
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                rd_en_i,
    input  logic                wr_en_i,
    input  logic [NUM_WAYS-1:0] wr_flush_i,
    input  logic                wr_evict_en_i,
    input  llc_pkg::llc_set_t   set_i,
    input  llc_pkg::llc_way_t   way_i,
    input  llc_pkg::llc_entry_t wr_entry_i,
    input  llc_pkg::llc_way_t   wr_evict_way_i,
    output llc_pkg::llc_entry_t rd_entry_o [NUM_WAYS],
    output llc_pkg::llc_way_t   rd_evict_way_o
);

    localparam int NUM_SETS = 1 << llc_pkg::SET_BITS;

    llc_pkg::llc_mixed_u mixed;
    llc_pkg::llc_mixed_u mask;
    logic [NUM_WAYS-1:0] meta_we;
    logic [NUM_WAYS-1:0] line_we;

    llc_write_ctrl #(
        .NUM_WAYS (NUM_WAYS)
    ) u_write_ctrl (
        .wr_en_i    (wr_en_i),
        .wr_flush_i (wr_flush_i),
        .way_i      (way_i),
        .wr_entry_i (wr_entry_i),
        .mixed_o    (mixed),
        .mask_o     (mask),
        .meta_we_o  (meta_we),
        .line_we_o  (line_we)
    );

    // all ways are read in parallel
    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        llc_way_bank #(
            .BANKS_PER_WAY (BANKS_PER_WAY)
        ) u_way_bank (
            .clk        (clk),
            .rd_en_i    (rd_en_i),
            .set_i      (set_i),
            .meta_we_i  (meta_we[w]),
            .line_we_i  (line_we[w]),
            .mixed_i    (mixed),
            .mask_i     (mask),
            .wr_entry_i (wr_entry_i),
            .rd_entry_o (rd_entry_o[w])
        );
    end

    llc_evict_ways #(
        .NUM_SETS (NUM_SETS)
    ) u_evict_ways (
        .clk      (clk),
        .rst      (rst),
        .wr_en_i  (wr_evict_en_i),
        .set_i    (set_i),
        .wr_way_i (wr_evict_way_i),
        .rd_way_o (rd_evict_way_o)
    );

    // a read and a memory write must not share a cycle
    a_rd_wr_excl: assert property (
        @(posedge clk) disable iff (!rst)
        rd_en_i |-> !(wr_en_i || (|wr_flush_i))
    ) else $error("read and write in the same cycle");

endmodule

//--- rtl/llc_evict_ways.sv
/* llc eviction way array */

`timescale 1ns/1ps

module llc_evict_ways #(
    parameter int NUM_SETS = 64
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              wr_en_i,
    input  llc_pkg::llc_set_t set_i,
    input  llc_pkg::llc_way_t wr_way_i,
    output llc_pkg::llc_way_t rd_way_o
);

    llc_pkg::llc_way_t evict_arr [NUM_SETS];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < NUM_SETS; i++) begin
                evict_arr[i] <= '0;
            end
        end else if (wr_en_i) begin
            evict_arr[set_i] <= wr_way_i;
        end
    end

    // sampled every cycle, so a same-edge write is not seen yet
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rd_way_o <= '0;
        end else begin
            rd_way_o <= evict_arr[set_i];
        end
    end

endmodule

//--- rtl/llc_way_bank.sv
/* banked memories of one llc way */

`timescale 1ns/1ps

module llc_way_bank #(
    parameter int BANKS_PER_WAY = 2
) (
    input  logic                clk,
    input  logic                rd_en_i,
    input  llc_pkg::llc_set_t   set_i,
    input  logic                meta_we_i,
    input  logic                line_we_i,
    input  llc_pkg::llc_mixed_u mixed_i,
    input  llc_pkg::llc_mixed_u mask_i,
    input  llc_pkg::llc_entry_t wr_entry_i,
    output llc_pkg::llc_entry_t rd_entry_o
);

    localparam int BANK_BITS  = $clog2(BANKS_PER_WAY);
    localparam int ADDR_BITS  = llc_pkg::SET_BITS - BANK_BITS;
    localparam int BANK_WORDS = 1 << ADDR_BITS;
    localparam int NUM_PARTS  = llc_pkg::LINE_BITS / llc_pkg::LINE_PART_BITS;

    logic [BANK_BITS-1:0] bank_sel;
    logic [BANK_BITS-1:0] bank_q;
    logic [ADDR_BITS-1:0] addr;

    logic [BANKS_PER_WAY-1:0] bank_hit;

    llc_pkg::llc_mixed_u   mixed_rd   [BANKS_PER_WAY];
    llc_pkg::llc_sharers_t sharers_rd [BANKS_PER_WAY];
    logic [llc_pkg::LINE_PART_BITS-1:0] line_rd [BANKS_PER_WAY][NUM_PARTS];

    if (BANKS_PER_WAY < 2) begin : g_bank_check
        $error("llc_way_bank needs at least two banks");
    end

    // top set bits pick the bank, the rest address inside it
    assign bank_sel = set_i[llc_pkg::SET_BITS-1 -: BANK_BITS];
    assign addr     = set_i[ADDR_BITS-1:0];

    always_comb begin
        for (int j = 0; j < BANKS_PER_WAY; j++) begin
            bank_hit[j] = (bank_sel == j);
        end
    end

    for (genvar j = 0; j < BANKS_PER_WAY; j++) begin : g_bank
        llc_sram_sp #(
            .DATA_WIDTH (llc_pkg::MIXED_BITS),
            .NUM_WORDS  (BANK_WORDS)
        ) u_mixed (
            .clk     (clk),
            .req_i   (rd_en_i && bank_hit[j]),
            .we_i    (meta_we_i && bank_hit[j]),
            .addr_i  (addr),
            .wdata_i (mixed_i.raw),
            .mask_i  (mask_i.raw),
            .rdata_o (mixed_rd[j].raw)
        );

        llc_sram_sp #(
            .DATA_WIDTH (llc_pkg::SHARERS_BITS),
            .NUM_WORDS  (BANK_WORDS)
        ) u_sharers (
            .clk     (clk),
            .req_i   (rd_en_i && bank_hit[j]),
            .we_i    (meta_we_i && bank_hit[j]),
            .addr_i  (addr),
            .wdata_i (wr_entry_i.sharers),
            .mask_i  ({llc_pkg::SHARERS_BITS{1'b1}}),
            .rdata_o (sharers_rd[j])
        );

        // line is split over two narrower memories
        for (genvar k = 0; k < NUM_PARTS; k++) begin : g_part
            llc_sram_sp #(
                .DATA_WIDTH (llc_pkg::LINE_PART_BITS),
                .NUM_WORDS  (BANK_WORDS)
            ) u_line (
                .clk     (clk),
                .req_i   (rd_en_i && bank_hit[j]),
                .we_i    (line_we_i && bank_hit[j]),
                .addr_i  (addr),
                .wdata_i (wr_entry_i.line[k*llc_pkg::LINE_PART_BITS +: llc_pkg::LINE_PART_BITS]),
                .mask_i  ({llc_pkg::LINE_PART_BITS{1'b1}}),
                .rdata_o (line_rd[j][k])
            );
        end
    end

    // remember which bank the last read went to
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            bank_q <= bank_sel;
        end
    end

    always_comb begin
        rd_entry_o.sharers = sharers_rd[bank_q];
        rd_entry_o.hprot   = mixed_rd[bank_q].fields.hprot;
        rd_entry_o.dirty   = mixed_rd[bank_q].fields.dirty;
        rd_entry_o.state   = mixed_rd[bank_q].fields.state;
        rd_entry_o.owner   = mixed_rd[bank_q].fields.owner;
        rd_entry_o.tag     = mixed_rd[bank_q].fields.tag;
        for (int k = 0; k < NUM_PARTS; k++) begin
            rd_entry_o.line[k*llc_pkg::LINE_PART_BITS +: llc_pkg::LINE_PART_BITS] =
                line_rd[bank_q][k];
        end
    end

endmodule

//--- rtl/llc_write_ctrl.sv
/* llc write control */

`timescale 1ns/1ps

module llc_write_ctrl #(
    parameter int NUM_WAYS = 4
) (
    input  logic                  wr_en_i,
    input  logic [NUM_WAYS-1:0]   wr_flush_i,
    input  llc_pkg::llc_way_t     way_i,
    input  llc_pkg::llc_entry_t   wr_entry_i,
    output llc_pkg::llc_mixed_u   mixed_o,
    output llc_pkg::llc_mixed_u   mask_o,
    output logic [NUM_WAYS-1:0]   meta_we_o,
    output logic [NUM_WAYS-1:0]   line_we_o
);

    logic flush_any;

    assign flush_any = |wr_flush_i;

    // pack the entry fields into the mixed word
    always_comb begin
        mixed_o.fields.hprot = wr_entry_i.hprot;
        mixed_o.fields.dirty = wr_entry_i.dirty;
        mixed_o.fields.state = wr_entry_i.state;
        mixed_o.fields.owner = wr_entry_i.owner;
        mixed_o.fields.tag   = wr_entry_i.tag;
    end

    // full write covers every field, a flush only dirty and state
    always_comb begin
        mask_o.raw = '0;
        if (wr_en_i) begin
            mask_o.raw = '1;
        end else if (flush_any) begin
            mask_o.fields.dirty = 1'b1;
            mask_o.fields.state = '1;
        end
    end

    // flagged ways take the flush, way_i takes the full write
    always_comb begin
        for (int i = 0; i < NUM_WAYS; i++) begin
            line_we_o[i] = wr_en_i && (way_i == i);
            meta_we_o[i] = wr_flush_i[i] || line_we_o[i];
        end
    end

    always_comb begin
        if (wr_en_i) begin
            a_way_range: assert final (!$isunknown(way_i) && way_i < NUM_WAYS)
                else $error("write to way %0d out of range", way_i);
        end
    end

endmodule

//--- rtl/llc_sram_sp.sv
/* single-port memory with bit mask */

`timescale 1ns/1ps

module llc_sram_sp #(
    parameter int DATA_WIDTH = 32,
    parameter int NUM_WORDS  = 64
) (
    input  logic                         clk,
    input  logic                         req_i,
    input  logic                         we_i,
    input  logic [$clog2(NUM_WORDS)-1:0] addr_i,
    input  logic [DATA_WIDTH-1:0]        wdata_i,
    input  logic [DATA_WIDTH-1:0]        mask_i,
    output logic [DATA_WIDTH-1:0]        rdata_o
);

    logic [DATA_WIDTH-1:0] mem [NUM_WORDS];

    // only masked bits change on a write
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[addr_i] <= (mem[addr_i] & ~mask_i) | (wdata_i & mask_i);
        end
    end

    // read data is held until the next read
    always_ff @(posedge clk) begin
        if (req_i && !we_i) begin
            rdata_o <= mem[addr_i];
        end
    end

    a_addr_valid: assert property (
        @(posedge clk) (req_i || we_i) |-> (!$isunknown(addr_i) && addr_i < NUM_WORDS)
    ) else $error("sram access with bad address %0h", addr_i);

endmodule

//--- rtl/llc_pkg.sv
/* llc local memory types */

package llc_pkg;

    localparam int SET_BITS       = 6;
    localparam int TAG_BITS       = 19;
    localparam int OWNER_BITS     = 4;
    localparam int STATE_BITS     = 3;
    localparam int SHARERS_BITS   = 16;
    localparam int LINE_BITS      = 128;
    localparam int LINE_PART_BITS = 64;
    localparam int MIXED_BITS     = 28;
    localparam int WAY_BITS       = 2;

    typedef logic [SET_BITS-1:0]     llc_set_t;
    typedef logic [WAY_BITS-1:0]     llc_way_t;
    typedef logic [TAG_BITS-1:0]     llc_tag_t;
    typedef logic [OWNER_BITS-1:0]   llc_owner_t;
    typedef logic [STATE_BITS-1:0]   llc_state_t;
    typedef logic [SHARERS_BITS-1:0] llc_sharers_t;
    typedef logic [LINE_BITS-1:0]    llc_line_t;

    // fields of the mixed memory word from the msb down
    typedef struct packed {
        logic       hprot;
        logic       dirty;
        llc_state_t state;
        llc_owner_t owner;
        llc_tag_t   tag;
    } llc_mixed_fields_t;

    // raw view is used for the bit mask, field view for packing
    typedef union packed {
        logic [MIXED_BITS-1:0] raw;
        llc_mixed_fields_t     fields;
    } llc_mixed_u;

    // one cache entry, as written and as read from each way
    typedef struct packed {
        llc_line_t    line;
        llc_sharers_t sharers;
        logic         hprot;
        logic         dirty;
        llc_state_t   state;
        llc_owner_t   owner;
        llc_tag_t     tag;
    } llc_entry_t;

endpackage
